/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// exception cause codes carried in excp_tag_t.ecode
// 6 bits wide, same encoding as the backend csr estat field

// no exception on this fetch
`define ECODE_NOP  6'h3f

// pending interrupt sampled at fetch time
`define ECODE_INT  6'h00

// fetch address not word aligned
`define ECODE_ADEF 6'h08

// interrupt wins only when the address is clean
// adef always takes precedence in the pc stage

`endif

/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int ADDR_W    = 32;
    localparam int INST_W    = 32;
    // btb tag is the pc above the bundle offset
    localparam int BTB_TAG_W = ADDR_W - 3;

    ////////////////////////////////////////
    // request types
    ////////////////////////////////////////

    // why a fetch is faulty
    typedef struct packed {
        logic       intr;
        logic       adef;
        logic [5:0] ecode;
    } excp_tag_t;

    // one fetch request, travels with the bundle
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        excp_tag_t         excp;
        logic              pred_taken;
        logic [ADDR_W-1:0] pred_target;
    } fetch_req_t;

    // btb set index, pc bits above bit 2 modulo the entry count
    function automatic int unsigned btb_index(input logic [ADDR_W-1:0] pc,
                                              input int unsigned entries);
        return 32'(pc[ADDR_W-1:3]) % entries;
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [ADDR_W-1:0] pc);
        return pc[ADDR_W-1:3];
    endfunction

endpackage

`default_nettype wire

/* design/fetch_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one fetch request from the pc stage
// no ready, valid is a one cycle strobe
interface fetch_if;
    import fetch_pkg::*;

    logic       valid;
    fetch_req_t req;
    // backend redirect, squashes everything in flight
    logic       kill;

    // pc stage side
    modport producer (
        output valid,
        output req,
        output kill
    );

    // rom and fetch stage side
    modport consumer (
        input valid,
        input req,
        input kill
    );

endinterface

`default_nettype wire

/* design/pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module pc_gen #(
    parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = 32'h100
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall_i,
    input  logic                          redirect_i,
    input  logic                          interrupt_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  redirect_pc_i,
    input  logic                          pred_taken_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  pred_target_i,
    output logic [fetch_pkg::ADDR_W-1:0]  pc_o,
    fetch_if.producer                     req_if
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0] pc_q;
    logic              issue;
    excp_tag_t         excp;

    // request goes out unless in reset, redirected or frozen
    assign issue = !rst && !redirect_i && !stall_i;

    ////////////////////////////////////////
    // next pc
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (!issue) begin
            // stall holds the pc
            pc_q <= pc_q;
        end else if (pred_taken_i) begin
            pc_q <= pred_target_i;
        end else begin
            // one bundle is two words
            pc_q <= pc_q + ADDR_W'(8);
        end
    end

    // exception tag with adef over int
    always_comb begin
        excp = '{intr: 1'b0, adef: 1'b0, ecode: `ECODE_NOP};
        if (pc_q[1:0] != 2'b00) begin
            excp.adef  = 1'b1;
            excp.ecode = `ECODE_ADEF;
        end else if (interrupt_i) begin
            excp.intr  = 1'b1;
            excp.ecode = `ECODE_INT;
        end
    end

    assign pc_o                   = pc_q;
    assign req_if.valid           = issue;
    assign req_if.kill            = redirect_i;
    assign req_if.req.pc          = pc_q;
    assign req_if.req.excp        = excp;
    // prediction for this pc rides along
    assign req_if.req.pred_taken  = pred_taken_i;
    assign req_if.req.pred_target = pred_target_i;

    // backend must hand over a known target with the strobe
    redirect_pc_known: assert property (
        @(posedge clk) disable iff (rst) redirect_i |-> !$isunknown(redirect_pc_i)
    );

endmodule

`default_nettype wire

/* design/branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_predictor #(
    parameter int BTB_ENTRIES = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [fetch_pkg::ADDR_W-1:0]  lookup_pc_i,
    output logic                          pred_taken_o,
    output logic [fetch_pkg::ADDR_W-1:0]  pred_target_o,
    input  logic                          update_i,
    input  logic                          update_taken_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  update_pc_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  update_target_i
);
    import fetch_pkg::*;

    localparam int IDX_W = (BTB_ENTRIES > 1) ? $clog2(BTB_ENTRIES) : 1;

    // per entry state
    logic [BTB_ENTRIES-1:0] vld_q;
    logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
    logic [ADDR_W-1:0]      tgt_q [BTB_ENTRIES];
    logic [1:0]             cnt_q [BTB_ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic             lk_hit;
    logic [IDX_W-1:0] up_idx;
    logic             up_hit;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    assign lk_idx = IDX_W'(btb_index(lookup_pc_i, BTB_ENTRIES));
    assign lk_hit = vld_q[lk_idx] && (tag_q[lk_idx] == btb_tag(lookup_pc_i));

    // weakly or strongly taken
    assign pred_taken_o  = lk_hit && cnt_q[lk_idx][1];
    assign pred_target_o = tgt_q[lk_idx];

    ////////////////////////////////////////
    // update
    ////////////////////////////////////////

    assign up_idx = IDX_W'(btb_index(update_pc_i, BTB_ENTRIES));
    assign up_hit = vld_q[up_idx] && (tag_q[up_idx] == btb_tag(update_pc_i));

    // only a taken branch allocates
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else if (update_i && update_taken_i) begin
            vld_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_i) begin
            if (update_taken_i) begin
                tag_q[up_idx] <= btb_tag(update_pc_i);
                tgt_q[up_idx] <= update_target_i;
                if (!up_hit) begin
                    // fresh entry, weakly taken
                    cnt_q[up_idx] <= 2'd2;
                end else if (cnt_q[up_idx] != 2'd3) begin
                    cnt_q[up_idx] <= cnt_q[up_idx] + 2'd1;
                end
            end else if (up_hit && cnt_q[up_idx] != 2'd0) begin
                cnt_q[up_idx] <= cnt_q[up_idx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/inst_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_rom #(
    parameter int ROM_DEPTH = 16
) (
    input  logic                          clk,
    fetch_if.consumer                     req_if,
    output logic [fetch_pkg::INST_W-1:0]  inst0_o,
    output logic [fetch_pkg::INST_W-1:0]  inst1_o
);
    import fetch_pkg::*;

    localparam int IDX_W = (ROM_DEPTH > 1) ? $clog2(ROM_DEPTH) : 1;

    logic [INST_W-1:0] mem [ROM_DEPTH];
    logic [IDX_W-1:0]  idx0;
    logic [IDX_W-1:0]  idx1;

    // program image
    initial begin
        $readmemh("fetch_frontend_rom.hex", mem);
    end

    ////////////////////////////////////////
    // two word read
    ////////////////////////////////////////

    // word index, wraps at the rom size
    assign idx0 = req_if.req.pc[IDX_W+1:2];
    assign idx1 = idx0 + IDX_W'(1);

    // data one cycle after the request
    always_ff @(posedge clk) begin
        if (req_if.valid) begin
            inst0_o <= mem[idx0];
            inst1_o <= mem[idx1];
        end
    end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                          clk,
    input  logic                          rst,
    fetch_if.consumer                     req_if,
    input  logic [fetch_pkg::INST_W-1:0]  inst0_i,
    input  logic [fetch_pkg::INST_W-1:0]  inst1_i,
    output logic                          bundle_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0]  bundle_pc_o,
    output logic [fetch_pkg::INST_W-1:0]  inst0_o,
    output logic [fetch_pkg::INST_W-1:0]  inst1_o,
    output logic [1:0]                    slot_valid_o,
    output fetch_pkg::excp_tag_t          excp_o,
    output logic                          pred_taken_o
);
    import fetch_pkg::*;

    // request held while the rom reads
    logic              s1_valid;
    logic [ADDR_W-1:0] s1_pc;
    excp_tag_t         s1_excp;
    logic              s1_pred_taken;

    ////////////////////////////////////////
    // stage 1, request
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || req_if.kill) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_if.valid) begin
            s1_pc         <= req_if.req.pc;
            s1_excp       <= req_if.req.excp;
            s1_pred_taken <= req_if.req.pred_taken;
        end
    end

    ////////////////////////////////////////
    // stage 2, bundle
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || req_if.kill) begin
            bundle_valid_o <= 1'b0;
        end else begin
            bundle_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            bundle_pc_o  <= s1_pc;
            excp_o       <= s1_excp;
            pred_taken_o <= s1_pred_taken;
            if (s1_excp.adef) begin
                // bad address leaves nothing to decode
                inst0_o      <= '0;
                inst1_o      <= '0;
                slot_valid_o <= 2'b00;
            end else begin
                inst0_o      <= inst0_i;
                inst1_o      <= inst1_i;
                // taken branch in slot 0 drops slot 1
                slot_valid_o <= {!s1_pred_taken, 1'b1};
            end
        end
    end

    // squash reaches the output register too
    no_bundle_after_kill: assert property (
        @(posedge clk) disable iff (rst) req_if.kill |=> !bundle_valid_o
    );

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC    = 32'h100,
    parameter int                           BTB_ENTRIES = 8,
    parameter int                           ROM_DEPTH   = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall_i,
    input  logic                          redirect_i,
    input  logic                          interrupt_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  redirect_pc_i,
    // branch outcome from the backend
    input  logic                          bp_update_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  bp_pc_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  bp_target_i,
    input  logic                          bp_taken_i,
    // bundle to decode
    output logic                          bundle_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0]  bundle_pc_o,
    output logic [fetch_pkg::INST_W-1:0]  inst0_o,
    output logic [fetch_pkg::INST_W-1:0]  inst1_o,
    output logic [1:0]                    slot_valid_o,
    output fetch_pkg::excp_tag_t          excp_o,
    output logic                          pred_taken_o
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic              pred_taken;
    logic [ADDR_W-1:0] pred_target;
    logic [INST_W-1:0] rom_inst0;
    logic [INST_W-1:0] rom_inst1;

    // pc stage to rom and fetch stage
    fetch_if fetch_req ();

    ////////////////////////////////////////
    // pc and prediction
    ////////////////////////////////////////

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .interrupt_i   (interrupt_i),
        .redirect_pc_i (redirect_pc_i),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .pc_o          (pc),
        .req_if        (fetch_req.producer)
    );

    branch_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_branch_predictor (
        .clk             (clk),
        .rst             (rst),
        .lookup_pc_i     (pc),
        .pred_taken_o    (pred_taken),
        .pred_target_o   (pred_target),
        .update_i        (bp_update_i),
        .update_taken_i  (bp_taken_i),
        .update_pc_i     (bp_pc_i),
        .update_target_i (bp_target_i)
    );

    ////////////////////////////////////////
    // rom and bundle
    ////////////////////////////////////////

    inst_rom #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_inst_rom (
        .clk     (clk),
        .req_if  (fetch_req.consumer),
        .inst0_o (rom_inst0),
        .inst1_o (rom_inst1)
    );

    fetch_stage u_fetch_stage (
        .clk            (clk),
        .rst            (rst),
        .req_if         (fetch_req.consumer),
        .inst0_i        (rom_inst0),
        .inst1_i        (rom_inst1),
        .bundle_valid_o (bundle_valid_o),
        .bundle_pc_o    (bundle_pc_o),
        .inst0_o        (inst0_o),
        .inst1_o        (inst1_o),
        .slot_valid_o   (slot_valid_o),
        .excp_o         (excp_o),
        .pred_taken_o   (pred_taken_o)
    );

endmodule

`default_nettype wire

/* bench/fetch_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defines.svh"

module fetch_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall_i,
    input  logic                          bundle_valid_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  bundle_pc_i,
    input  logic [fetch_pkg::INST_W-1:0]  inst0_i,
    input  logic [fetch_pkg::INST_W-1:0]  inst1_i,
    input  logic [1:0]                    slot_valid_i,
    input  fetch_pkg::excp_tag_t          excp_i,
    input  logic                          pred_taken_i,
    input  logic                          arm_i,
    input  logic                          chk_lat_i,
    input  logic                          exp_int_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  exp_pc_i,
    input  logic                          train_vld_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  train_pc_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  train_tgt_i,
    output logic                          done_o,
    output int                            err_count_o
);
    import fetch_pkg::*;

    logic              armed;
    logic              chk_lat;
    logic              exp_int;
    logic [ADDR_W-1:0] exp_pc;
    int                lat;
    int                stall_bundles;
    logic              have_prev;
    logic              prev_taken;
    logic [ADDR_W-1:0] prev_pc;
    logic [ADDR_W-1:0] want_pc;
    logic [INST_W-1:0] want0;
    logic [INST_W-1:0] want1;
    logic              want_taken;
    logic [1:0]        want_slot;
    excp_tag_t         want_excp;
    logic [3:0]        idx;
    logic              first;

    initial begin
        err_count_o = 0;
    end

    task automatic flag(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        err_count_o = err_count_o + 1;
    endtask

    ////////////////////////////////////////
    // compare at the falling edge once outputs settle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            armed         = 1'b0;
            done_o        = 1'b0;
            have_prev     = 1'b0;
            prev_taken    = 1'b0;
            stall_bundles = 0;
            lat           = 0;
        end else begin
            if (armed) begin
                lat = lat + 1;
            end
            // a new row counts from its request cycle
            if (arm_i) begin
                armed   = 1'b1;
                done_o  = 1'b0;
                lat     = 0;
                exp_pc  = exp_pc_i;
                chk_lat = chk_lat_i;
                exp_int = exp_int_i;
            end
            if (bundle_valid_i) begin
                first = armed;
                // pc is the handed over one, the trained target or the next bundle
                if (first && exp_pc != '0) begin
                    want_pc = exp_pc;
                end else if (prev_taken) begin
                    want_pc = train_tgt_i;
                end else begin
                    want_pc = prev_pc + 32'd8;
                end
                if ((first && exp_pc != '0) || have_prev) begin
                    if (bundle_pc_i != want_pc) begin
                        flag($sformatf("bundle pc %h, expected %h", bundle_pc_i, want_pc));
                    end
                end
                if (first && chk_lat && lat != 2) begin
                    flag($sformatf("bundle %0d cycles after request, expected 2", lat));
                end
                // rom word k holds a5000000 plus k
                idx        = bundle_pc_i[5:2];
                want_taken = train_vld_i && (bundle_pc_i == train_pc_i);
                if (bundle_pc_i[1:0] != 2'b00) begin
                    want0     = '0;
                    want1     = '0;
                    want_slot = 2'b00;
                    want_excp = '{intr: 1'b0, adef: 1'b1, ecode: `ECODE_ADEF};
                end else begin
                    want0     = 32'hA500_0000 + {28'h0, idx};
                    want1     = 32'hA500_0000 + {28'h0, idx + 4'd1};
                    want_slot = {!want_taken, 1'b1};
                    if (first && exp_int) begin
                        want_excp = '{intr: 1'b1, adef: 1'b0, ecode: `ECODE_INT};
                    end else begin
                        want_excp = '{intr: 1'b0, adef: 1'b0, ecode: `ECODE_NOP};
                    end
                end
                if (inst0_i != want0 || inst1_i != want1) begin
                    flag($sformatf("pc %h words %h %h, expected %h %h",
                                   bundle_pc_i, inst0_i, inst1_i, want0, want1));
                end
                if (slot_valid_i != want_slot) begin
                    flag($sformatf("pc %h slots %b, expected %b",
                                   bundle_pc_i, slot_valid_i, want_slot));
                end
                if (excp_i != want_excp) begin
                    flag($sformatf("pc %h excp %h, expected %h", bundle_pc_i, excp_i, want_excp));
                end
                if (pred_taken_i != want_taken) begin
                    flag($sformatf("pc %h pred_taken %b, expected %b",
                                   bundle_pc_i, pred_taken_i, want_taken));
                end
                have_prev  = 1'b1;
                prev_pc    = bundle_pc_i;
                prev_taken = want_taken;
                if (first) begin
                    armed  = 1'b0;
                    done_o = 1'b1;
                end
            end
            // only the two items in flight may leave during a stall
            if (stall_i) begin
                if (bundle_valid_i) begin
                    stall_bundles = stall_bundles + 1;
                end
                if (bundle_valid_i && stall_bundles == 3) begin
                    flag("third bundle emerged during a stall");
                end
            end else begin
                stall_bundles = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* include/fetch_tb_rows.svh */
`ifndef FETCH_TB_ROWS_SVH
`define FETCH_TB_ROWS_SVH

// row operations of the fetch testbench table
`define OP_RUN      3'd0
`define OP_REDIRECT 3'd1
`define OP_STALL    3'd2
`define OP_TRAIN    3'd3
`define OP_UNTRAIN  3'd4
`define OP_INT      3'd5

`endif

/* bench/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_tb_rows.svh"

module fetch_tb;
    import fetch_pkg::*;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic [31:0] target;
        logic [7:0]  cycles;
        logic [31:0] exp_pc;
    } row_t;

    localparam int NUM_ROWS = 10;
    localparam int TIMEOUT  = 50;

    logic clk;
    logic rst;
    logic stall_i;
    logic redirect_i;
    logic interrupt_i;
    logic [31:0] redirect_pc_i;
    logic bp_update_i;
    logic [31:0] bp_pc_i;
    logic [31:0] bp_target_i;
    logic bp_taken_i;
    logic bundle_valid;
    logic [31:0] bundle_pc;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [1:0] slot_valid;
    excp_tag_t excp;
    logic pred_taken;
    // handshake with the checker
    logic arm;
    logic chk_lat;
    logic exp_int;
    logic [31:0] exp_pc;
    logic train_vld;
    logic [31:0] train_pc;
    logic [31:0] train_tgt;
    logic done;
    int err_count;
    row_t rows [NUM_ROWS];
    int fails;

    fetch_top UUT (
        .clk (clk), .rst (rst), .stall_i (stall_i), .redirect_i (redirect_i),
        .interrupt_i (interrupt_i), .redirect_pc_i (redirect_pc_i),
        .bp_update_i (bp_update_i), .bp_pc_i (bp_pc_i), .bp_target_i (bp_target_i),
        .bp_taken_i (bp_taken_i), .bundle_valid_o (bundle_valid), .bundle_pc_o (bundle_pc),
        .inst0_o (inst0), .inst1_o (inst1), .slot_valid_o (slot_valid),
        .excp_o (excp), .pred_taken_o (pred_taken)
    );

    fetch_checker u_checker (
        .clk (clk), .rst (rst), .stall_i (stall_i), .bundle_valid_i (bundle_valid),
        .bundle_pc_i (bundle_pc), .inst0_i (inst0), .inst1_i (inst1),
        .slot_valid_i (slot_valid), .excp_i (excp), .pred_taken_i (pred_taken),
        .arm_i (arm), .chk_lat_i (chk_lat), .exp_int_i (exp_int), .exp_pc_i (exp_pc),
        .train_vld_i (train_vld), .train_pc_i (train_pc), .train_tgt_i (train_tgt),
        .done_o (done), .err_count_o (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    initial begin
        // op, addr, target, cycles after, expected pc (0 means next in sequence)
        rows[0] = '{`OP_RUN,      32'h0,   32'h0,   8'd6, 32'h100};
        rows[1] = '{`OP_REDIRECT, 32'h180, 32'h0,   8'd5, 32'h180};
        rows[2] = '{`OP_STALL,    32'h0,   32'h0,   8'd4, 32'h0};
        rows[3] = '{`OP_TRAIN,    32'h120, 32'h140, 8'd6, 32'h120};
        rows[4] = '{`OP_UNTRAIN,  32'h120, 32'h0,   8'd6, 32'h120};
        rows[5] = '{`OP_REDIRECT, 32'h1A2, 32'h0,   8'd4, 32'h1A2};
        rows[6] = '{`OP_REDIRECT, 32'h200, 32'h0,   8'd4, 32'h200};
        rows[7] = '{`OP_INT,      32'h0,   32'h0,   8'd4, 32'h0};
        rows[8] = '{`OP_STALL,    32'h0,   32'h0,   8'd4, 32'h0};
        rows[9] = '{`OP_RUN,      32'h0,   32'h0,   8'd8, 32'h0};
    end

    // hand the expected pc to the checker for one cycle
    task automatic arm_checker(input logic [31:0] pc, input logic lat, input logic intr);
        arm     <= 1'b1;
        exp_pc  <= pc;
        chk_lat <= lat;
        exp_int <= intr;
        @(posedge clk);
        arm     <= 1'b0;
        interrupt_i <= 1'b0;
    endtask

    // freeze requests until the two in flight have left
    task automatic drain();
        stall_i <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic apply_row(input row_t r);
        int n;
        case (r.op)
            `OP_REDIRECT: begin
                redirect_i    <= 1'b1;
                redirect_pc_i <= r.addr;
                @(posedge clk);
                redirect_i <= 1'b0;
                arm_checker(r.exp_pc, 1'b1, 1'b0);
            end
            `OP_STALL: begin
                n = 3 + int'($urandom % 6);
                stall_i <= 1'b1;
                repeat (n) @(posedge clk);
                stall_i <= 1'b0;
                arm_checker(r.exp_pc, 1'b0, 1'b0);
            end
            `OP_TRAIN, `OP_UNTRAIN: begin
                drain();
                // two back to back update strobes
                bp_update_i <= 1'b1;
                bp_pc_i     <= r.addr;
                bp_target_i <= r.target;
                bp_taken_i  <= (r.op == `OP_TRAIN);
                repeat (2) @(posedge clk);
                bp_update_i   <= 1'b0;
                train_vld     <= (r.op == `OP_TRAIN);
                train_pc      <= r.addr;
                train_tgt     <= r.target;
                redirect_i    <= 1'b1;
                redirect_pc_i <= r.addr;
                @(posedge clk);
                redirect_i <= 1'b0;
                stall_i    <= 1'b0;
                arm_checker(r.exp_pc, 1'b1, 1'b0);
            end
            `OP_INT: begin
                drain();
                stall_i     <= 1'b0;
                interrupt_i <= 1'b1;
                arm_checker(r.exp_pc, 1'b1, 1'b1);
            end
            default: begin
                arm_checker(r.exp_pc, 1'b0, 1'b0);
            end
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int t;
        int err_before;
        rst = 1'b1;
        stall_i = 1'b0;
        redirect_i = 1'b0;
        interrupt_i = 1'b0;
        redirect_pc_i = '0;
        bp_update_i = 1'b0;
        bp_pc_i = '0;
        bp_target_i = '0;
        bp_taken_i = 1'b0;
        arm = 1'b0;
        chk_lat = 1'b0;
        exp_int = 1'b0;
        exp_pc = '0;
        train_vld = 1'b0;
        train_pc = '0;
        train_tgt = '0;
        fails = 0;
        void'($urandom(32'h7129));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            err_before = err_count;
            apply_row(rows[i]);
            t = 0;
            while (!done && t < TIMEOUT) begin
                @(posedge clk);
                t++;
            end
            if (!done) begin
                $display("test %0d: no bundle arrived within %0d cycles", i, TIMEOUT);
                fails++;
            end else if (err_count != err_before) begin
                $display("test %0d: %0d mismatches", i, err_count - err_before);
                fails++;
            end else begin
                $display("test %0d: ok", i);
            end
            repeat (int'(rows[i].cycles)) @(posedge clk);
        end
        $display("tests %0d, passed %0d, failed %0d, checker errors %0d",
                 NUM_ROWS, NUM_ROWS - fails, fails, err_count);
        if (fails == 0 && err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_frontend_rom.hex */
A5000000
A5000001
A5000002
A5000003
A5000004
A5000005
A5000006
A5000007
A5000008
A5000009
A500000A
A500000B
A500000C
A500000D
A500000E
A500000F

/* fetch_frontend.f */
+incdir+include
design/fetch_pkg.sv
design/fetch_if.sv
design/pc_gen.sv
design/branch_predictor.sv
design/inst_rom.sv
design/fetch_stage.sv
design/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module fetch_tb \
    -f fetch_frontend.f --Mdir obj_dir -o fetch_sim \
    && ./obj_dir/fetch_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -qx '>>> PASS' sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
